//--- design/pipe_ctrl_consts.svh
// pipeline control constants
`ifndef PIPE_CTRL_CONSTS_SVH
`define PIPE_CTRL_CONSTS_SVH

// register file address width
`define RV_REG_ADDR_W 5

// base ISA word width
`define RV_XLEN 32

// opcode field width, 7 bits for the 32-bit base ISA
`define RV_OPCODE_W ($clog2(`RV_XLEN) + 2)

// fetch, decode, execute, memory, writeback
`define PIPE_STAGES 5

// in-flight destination slots, one per stage after decode
`define HZD_DEPTH 3

`endif

//--- design/pipe_ctrl_pkg.sv
// pipeline control types
`include "pipe_ctrl_consts.svh"

package pipe_ctrl_pkg;

    typedef enum logic [`RV_OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_xor, alu_or, alu_and
    } alu_op_e;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {amux1_rs1, amux1_pc} alumux1_e;

    typedef enum logic [2:0] {
        amux2_i_imm, amux2_u_imm, amux2_b_imm, amux2_s_imm, amux2_j_imm, amux2_rs2
    } alumux2_e;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmpmux_e;
    typedef enum logic [1:0] {exefwd_alu_out, exefwd_u_imm, exefwd_br_en_zext} exefwd_e;
    typedef enum logic {memfwd_mem, memfwd_exe} memfwd_e;

    typedef enum logic [3:0] {
        rf_alu_out, rf_u_imm, rf_br_en, rf_pc_plus4, rf_lb, rf_lh, rf_lw, rf_lbu, rf_lhu
    } regfile_sel_e;

    typedef enum logic {mar_pc, mar_alu_out} marmux_e;

    // nearest-first order, slot 0 maps to fwd_exe
    typedef enum logic [1:0] {fwd_rf_data, fwd_exe, fwd_mem, fwd_wb} fwd_sel_e;
    typedef enum logic [1:0] {pc_plus4, pc_alu_out, pc_alu_mod2} pcmux_e;

    typedef struct packed {
        rv_opcode_e                 opcode;
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic [`RV_REG_ADDR_W-1:0]  rs1;
        logic [`RV_REG_ADDR_W-1:0]  rs2;
        logic [2:0]                 funct3;
        logic                       funct7_5;
    } decoded_instr_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alumux1_e  alumux1_sel;
        alumux2_e  alumux2_sel;
        cmp_op_e   cmp_op;
        cmpmux_e   cmpmux_sel;
        exefwd_e   exefwd_sel;
        fwd_sel_e  rs1_sel;
        fwd_sel_e  rs2_sel;
    } exe_ctrl_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [2:0]  funct3;
        marmux_e     mar_sel;
        memfwd_e     memfwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic                       ld_reg;
        regfile_sel_e               regfile_sel;
        logic [`RV_REG_ADDR_W-1:0]  rd;
    } wb_ctrl_t;

    typedef struct packed {
        exe_ctrl_t  exe;
        mem_ctrl_t  mem;
        wb_ctrl_t   wb;
    } ctrl_word_t;

    // bit 0 is fetch, bit 4 is writeback
    typedef struct packed {
        logic [`PIPE_STAGES-1:0]  valid;
        logic [`PIPE_STAGES-1:0]  ready;
    } stage_status_t;

    typedef struct packed {
        logic if_de;
        logic de_exe;
        logic exe_mem;
        logic mem_wb;
    } pipe_ld_t;

    typedef struct packed {
        logic if_de;
        logic de_exe;
        logic exe_mem;
        logic mem_wb;
    } pipe_flush_t;

    typedef struct packed {
        logic rs1_used;
        logic rs2_used;
    } reg_use_t;

endpackage

//--- design/instr_decoder.sv
// RV32I instruction decoder
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module instr_decoder (
    input  pipe_ctrl_pkg::decoded_instr_t  i_instr,
    input  logic                           i_if_rdy,
    output pipe_ctrl_pkg::ctrl_word_t      o_ctrl,
    output pipe_ctrl_pkg::reg_use_t        o_reg_use,
    output logic [`RV_REG_ADDR_W-1:0]      o_dest_tag
);
    import pipe_ctrl_pkg::*;

    logic is_reg;

    assign is_reg = (i_instr.opcode == op_reg);

    // branches and stores write no register
    assign o_dest_tag = (i_if_rdy && i_instr.opcode != op_br && i_instr.opcode != op_store)
                      ? i_instr.rd : '0;

    always_comb begin
        // defaults also form the bubble word
        o_ctrl.exe.alu_op      = alu_add;
        o_ctrl.exe.alumux1_sel = amux1_rs1;
        o_ctrl.exe.alumux2_sel = amux2_i_imm;
        o_ctrl.exe.cmp_op      = cmp_beq;
        o_ctrl.exe.cmpmux_sel  = cmp_rs2;
        o_ctrl.exe.exefwd_sel  = exefwd_alu_out;
        o_ctrl.exe.rs1_sel     = fwd_rf_data;
        o_ctrl.exe.rs2_sel     = fwd_rf_data;
        o_ctrl.mem.read        = 1'b0;
        o_ctrl.mem.write       = 1'b0;
        o_ctrl.mem.funct3      = 3'b000;
        o_ctrl.mem.mar_sel     = mar_pc;
        o_ctrl.mem.memfwd_sel  = memfwd_mem;
        o_ctrl.wb.ld_reg       = 1'b0;
        o_ctrl.wb.regfile_sel  = rf_alu_out;
        o_ctrl.wb.rd           = '0;
        o_reg_use              = '0;

        if (i_if_rdy) begin
            unique case (i_instr.opcode)
                op_lui: begin
                    o_ctrl.exe.exefwd_sel = exefwd_u_imm;
                    o_ctrl.mem.memfwd_sel = memfwd_exe;
                    o_ctrl.wb.ld_reg      = 1'b1;
                    o_ctrl.wb.regfile_sel = rf_u_imm;
                    o_ctrl.wb.rd          = i_instr.rd;
                end
                op_auipc, op_jal: begin
                    o_ctrl.exe.alumux1_sel = amux1_pc;
                    o_ctrl.exe.alumux2_sel = (i_instr.opcode == op_jal) ? amux2_j_imm
                                                                        : amux2_u_imm;
                    o_ctrl.mem.memfwd_sel  = memfwd_exe;
                    o_ctrl.wb.ld_reg       = 1'b1;
                    o_ctrl.wb.regfile_sel  = (i_instr.opcode == op_jal) ? rf_pc_plus4
                                                                        : rf_alu_out;
                    o_ctrl.wb.rd           = i_instr.rd;
                end
                op_jalr: begin
                    o_ctrl.mem.memfwd_sel = memfwd_exe;
                    o_ctrl.wb.ld_reg      = 1'b1;
                    o_ctrl.wb.regfile_sel = rf_pc_plus4;
                    o_ctrl.wb.rd          = i_instr.rd;
                    o_reg_use.rs1_used    = 1'b1;
                end
                op_br: begin
                    // target computed in the ALU, condition in the comparator
                    o_ctrl.exe.alumux1_sel = amux1_pc;
                    o_ctrl.exe.alumux2_sel = amux2_b_imm;
                    if (i_instr.funct3[2:1] != 2'b01) begin
                        o_ctrl.exe.cmp_op = cmp_op_e'(i_instr.funct3);
                    end
                    o_ctrl.mem.memfwd_sel  = memfwd_exe;
                    o_reg_use              = '{rs1_used: 1'b1, rs2_used: 1'b1};
                end
                op_load: begin
                    o_ctrl.mem.read    = 1'b1;
                    o_ctrl.mem.funct3  = i_instr.funct3;
                    o_ctrl.mem.mar_sel = mar_alu_out;
                    o_ctrl.wb.ld_reg   = 1'b1;
                    o_ctrl.wb.rd       = i_instr.rd;
                    o_reg_use.rs1_used = 1'b1;
                    case (i_instr.funct3)
                        3'b000:  o_ctrl.wb.regfile_sel = rf_lb;
                        3'b001:  o_ctrl.wb.regfile_sel = rf_lh;
                        3'b100:  o_ctrl.wb.regfile_sel = rf_lbu;
                        3'b101:  o_ctrl.wb.regfile_sel = rf_lhu;
                        default: o_ctrl.wb.regfile_sel = rf_lw;
                    endcase
                end
                op_store: begin
                    o_ctrl.exe.alumux2_sel = amux2_s_imm;
                    o_ctrl.mem.write       = 1'b1;
                    o_ctrl.mem.funct3      = i_instr.funct3;
                    o_ctrl.mem.mar_sel     = mar_alu_out;
                    o_reg_use              = '{rs1_used: 1'b1, rs2_used: 1'b1};
                end
                op_imm, op_reg: begin
                    // same funct3 table, second operand differs
                    o_ctrl.exe.alumux2_sel = is_reg ? amux2_rs2 : amux2_i_imm;
                    o_ctrl.exe.cmpmux_sel  = is_reg ? cmp_rs2 : cmp_i_imm;
                    o_ctrl.mem.memfwd_sel  = memfwd_exe;
                    o_ctrl.wb.ld_reg       = 1'b1;
                    o_ctrl.wb.rd           = i_instr.rd;
                    o_reg_use              = '{rs1_used: 1'b1, rs2_used: is_reg};
                    case (i_instr.funct3)
                        3'b000: o_ctrl.exe.alu_op = (is_reg && i_instr.funct7_5) ? alu_sub
                                                                                 : alu_add;
                        3'b001: o_ctrl.exe.alu_op = alu_sll;
                        3'b010, 3'b011: begin
                            // slt and sltu come from the comparator
                            o_ctrl.exe.cmp_op     = i_instr.funct3[0] ? cmp_bltu : cmp_blt;
                            o_ctrl.exe.exefwd_sel = exefwd_br_en_zext;
                            o_ctrl.wb.regfile_sel = rf_br_en;
                        end
                        3'b100: o_ctrl.exe.alu_op = alu_xor;
                        3'b101: o_ctrl.exe.alu_op = i_instr.funct7_5 ? alu_sra : alu_srl;
                        3'b110: o_ctrl.exe.alu_op = alu_or;
                        default: o_ctrl.exe.alu_op = alu_and;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        a_mem_excl: assert final (!(o_ctrl.mem.read && o_ctrl.mem.write));
    end

endmodule

//--- design/hazard_slot.sv
// in-flight destination queue slot
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module hazard_slot #(
    parameter int TAG_W = `RV_REG_ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_shift,
    input  logic              i_kill,
    input  logic [TAG_W-1:0]  i_tag,
    input  logic              i_tag_valid,
    output logic [TAG_W-1:0]  o_tag,
    output logic              o_tag_valid
);

    // kill wins over shift
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_tag       <= '0;
            o_tag_valid <= 1'b0;
        end else if (i_kill) begin
            o_tag       <= '0;
            o_tag_valid <= 1'b0;
        end else if (i_shift) begin
            o_tag       <= i_tag;
            o_tag_valid <= i_tag_valid;
        end
    end

endmodule

//--- design/forward_select.sv
// operand forwarding select
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module forward_select (
    input  logic [`RV_REG_ADDR_W-1:0]  i_rs1,
    input  logic [`RV_REG_ADDR_W-1:0]  i_rs2,
    input  pipe_ctrl_pkg::reg_use_t    i_reg_use,
    input  logic [`RV_REG_ADDR_W-1:0]  i_slot_tag [`HZD_DEPTH],
    input  logic [`HZD_DEPTH-1:0]      i_slot_valid,
    output pipe_ctrl_pkg::fwd_sel_e    o_rs1_sel,
    output pipe_ctrl_pkg::fwd_sel_e    o_rs2_sel
);
    import pipe_ctrl_pkg::*;

    // oldest slot first so the nearest match overwrites
    function automatic fwd_sel_e pick(
        input logic [`RV_REG_ADDR_W-1:0]  rs,
        input logic                       used,
        input logic [`RV_REG_ADDR_W-1:0]  tags [`HZD_DEPTH],
        input logic [`HZD_DEPTH-1:0]      valid
    );
        fwd_sel_e sel;
        sel = fwd_rf_data;
        if (used && rs != '0) begin
            for (int i = `HZD_DEPTH - 1; i >= 0; i--) begin
                if (valid[i] && tags[i] == rs) begin
                    sel = fwd_sel_e'(i + 1);
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_rs1_sel = pick(i_rs1, i_reg_use.rs1_used, i_slot_tag, i_slot_valid);
        o_rs2_sel = pick(i_rs2, i_reg_use.rs2_used, i_slot_tag, i_slot_valid);
    end

    // x0 is never forwarded even if a tag of zero sits in the queue
    always_comb begin
        if (i_rs1 == '0) begin
            a_rs1_zero: assert final (o_rs1_sel == fwd_rf_data);
        end
        if (i_rs2 == '0) begin
            a_rs2_zero: assert final (o_rs2_sel == fwd_rf_data);
        end
    end

endmodule

//--- design/stall_ctrl.sv
// stall, flush and next-PC control
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module stall_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  pipe_ctrl_pkg::stage_status_t  i_status,
    input  logic                          i_icache_resp,
    input  logic                          i_br_en,
    input  pipe_ctrl_pkg::rv_opcode_e     i_opcode_exec,
    output pipe_ctrl_pkg::pipe_ld_t       o_ld,
    output pipe_ctrl_pkg::pipe_flush_t    o_flush,
    output logic                          o_shift,
    output logic                          o_kill_young,
    output logic                          o_imem_read,
    output logic                          o_load_pc,
    output pipe_ctrl_pkg::pcmux_e         o_pcmux_sel
);
    import pipe_ctrl_pkg::*;

    logic [`PIPE_STAGES-1:0]  pend;
    logic [`PIPE_STAGES-2:0]  stall;
    logic                     br_now;
    logic                     br_taken_q;

    // stage holding a result it cannot hand on
    assign pend = i_status.valid & ~i_status.ready;

    // register k stalls on any pending stage after k
    always_comb begin
        stall[`PIPE_STAGES-2] = pend[`PIPE_STAGES-1];
        for (int k = `PIPE_STAGES - 3; k >= 0; k--) begin
            stall[k] = stall[k+1] | pend[k+1];
        end
    end

    assign br_now = i_br_en && (i_opcode_exec == op_br);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            br_taken_q <= 1'b0;
        end else begin
            br_taken_q <= br_now;
        end
    end

    always_comb begin
        o_ld.if_de    = !rst && i_icache_resp && !stall[0];
        o_ld.de_exe   = !rst && i_icache_resp && !stall[1] && i_status.valid[0];
        o_ld.exe_mem  = !rst && i_icache_resp && !stall[2] && i_status.valid[1];
        o_ld.mem_wb   = !rst && i_icache_resp && !stall[3] && i_status.valid[2];
        o_imem_read   = !rst && !i_icache_resp && !stall[0];
        o_load_pc     = !rst && i_icache_resp && (br_taken_q || !stall[0]);
        // younger two registers hold wrong-path work after a taken branch
        o_flush.if_de   = rst || br_taken_q;
        o_flush.de_exe  = rst || br_taken_q;
        o_flush.exe_mem = rst;
        o_flush.mem_wb  = rst;
    end

    // queue moves with the fetch/decode register
    assign o_shift      = o_ld.if_de;
    assign o_kill_young = br_taken_q;

    always_comb begin
        if (br_now || i_opcode_exec == op_jal) begin
            o_pcmux_sel = pc_alu_out;
        end else if (i_opcode_exec == op_jalr) begin
            o_pcmux_sel = pc_alu_mod2;
        end else begin
            o_pcmux_sel = pc_plus4;
        end
    end

    a_ld_needs_resp: assert property (@(posedge clk) disable iff (rst)
        !i_icache_resp |-> (o_ld == '0));

endmodule

//--- design/pipe_ctrl_top.sv
// pipeline control unit top level
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module pipe_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,
    input  pipe_ctrl_pkg::decoded_instr_t i_instr,
    input  pipe_ctrl_pkg::stage_status_t  i_status,
    input  logic                          i_icache_resp,
    input  logic                          i_br_en,
    input  pipe_ctrl_pkg::rv_opcode_e     i_opcode_exec,
    output pipe_ctrl_pkg::ctrl_word_t     o_ctrl_word,
    output pipe_ctrl_pkg::pipe_ld_t       o_ld,
    output pipe_ctrl_pkg::pipe_flush_t    o_flush,
    output logic                          o_imem_read,
    output logic                          o_load_pc,
    output pipe_ctrl_pkg::pcmux_e         o_pcmux_sel
);
    import pipe_ctrl_pkg::*;

    ctrl_word_t                 dec_ctrl;
    reg_use_t                   reg_use;
    logic [`RV_REG_ADDR_W-1:0]  dest_tag;
    logic [`RV_REG_ADDR_W-1:0]  in_tag   [`HZD_DEPTH];
    logic [`RV_REG_ADDR_W-1:0]  slot_tag [`HZD_DEPTH];
    logic [`HZD_DEPTH-1:0]      in_valid;
    logic [`HZD_DEPTH-1:0]      slot_valid;
    fwd_sel_e                   rs1_sel;
    fwd_sel_e                   rs2_sel;
    logic                       shift;
    logic                       kill_young;

    instr_decoder decoder_i (
        .i_instr    (i_instr),
        .i_if_rdy   (i_status.ready[0]),
        .o_ctrl     (dec_ctrl),
        .o_reg_use  (reg_use),
        .o_dest_tag (dest_tag)
    );

    // slot 0 is the instruction just ahead of decode
    for (genvar g = 0; g < `HZD_DEPTH; g++) begin : g_slot
        if (g == 0) begin : g_head
            assign in_tag[g]   = dest_tag;
            assign in_valid[g] = i_status.ready[0];
        end else begin : g_tail
            assign in_tag[g]   = slot_tag[g-1];
            assign in_valid[g] = slot_valid[g-1];
        end

        hazard_slot slot_i (
            .clk         (clk),
            .rst         (rst),
            .i_shift     (shift),
            .i_kill      (kill_young && (g < 2)),
            .i_tag       (in_tag[g]),
            .i_tag_valid (in_valid[g]),
            .o_tag       (slot_tag[g]),
            .o_tag_valid (slot_valid[g])
        );
    end

    forward_select fwd_i (
        .i_rs1        (i_instr.rs1),
        .i_rs2        (i_instr.rs2),
        .i_reg_use    (reg_use),
        .i_slot_tag   (slot_tag),
        .i_slot_valid (slot_valid),
        .o_rs1_sel    (rs1_sel),
        .o_rs2_sel    (rs2_sel)
    );

    stall_ctrl stall_i (
        .clk           (clk),
        .rst           (rst),
        .i_status      (i_status),
        .i_icache_resp (i_icache_resp),
        .i_br_en       (i_br_en),
        .i_opcode_exec (i_opcode_exec),
        .o_ld          (o_ld),
        .o_flush       (o_flush),
        .o_shift       (shift),
        .o_kill_young  (kill_young),
        .o_imem_read   (o_imem_read),
        .o_load_pc     (o_load_pc),
        .o_pcmux_sel   (o_pcmux_sel)
    );

    always_comb begin
        o_ctrl_word             = dec_ctrl;
        o_ctrl_word.exe.rs1_sel = rs1_sel;
        o_ctrl_word.exe.rs2_sel = rs2_sel;
    end

endmodule

//--- testbench/tb_pipe_ctrl.sv
// pipeline control testbench
`timescale 1ns/100ps
`include "pipe_ctrl_consts.svh"

module tb_pipe_ctrl;
    import pipe_ctrl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 10;
    localparam int RUN_CYCLES = 2000;
    // run length plus ten percent
    localparam int TIMEOUT    = RUN_CYCLES + RUN_CYCLES / 10;
    localparam rv_opcode_e OPS [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                                      op_load, op_store, op_imm, op_reg};

    logic            clk;
    logic            rst;
    decoded_instr_t  i_instr;
    stage_status_t   i_status;
    logic            i_icache_resp;
    logic            i_br_en;
    rv_opcode_e      i_opcode_exec;
    ctrl_word_t      o_ctrl_word;
    pipe_ld_t        o_ld;
    pipe_flush_t     o_flush;
    logic            o_imem_read;
    logic            o_load_pc;
    pcmux_e          o_pcmux_sel;

    // reference queue, slot 0 nearest
    logic [`RV_REG_ADDR_W-1:0]  m_tag [`HZD_DEPTH];
    logic [`HZD_DEPTH-1:0]      m_valid;
    logic                       m_br_q;

    logic [31:0]  rng;
    int           cycles = 0;
    int           checks = 0;
    int           errors = 0;

    pipe_ctrl_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_instr       (i_instr),
        .i_status      (i_status),
        .i_icache_resp (i_icache_resp),
        .i_br_en       (i_br_en),
        .i_opcode_exec (i_opcode_exec),
        .o_ctrl_word   (o_ctrl_word),
        .o_ld          (o_ld),
        .o_flush       (o_flush),
        .o_imem_read   (o_imem_read),
        .o_load_pc     (o_load_pc),
        .o_pcmux_sel   (o_pcmux_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // expected control word, forwarding selects still at rf_data
    task automatic decode_expect(
        input  decoded_instr_t  ins,
        input  logic            rdy,
        output ctrl_word_t      c,
        output reg_use_t        use_o
    );
        logic wr_rd;
        logic is_r;
        c     = '0;
        use_o = '0;
        wr_rd = 1'b0;
        is_r  = (ins.opcode == op_reg);
        if (rdy) begin
            case (ins.opcode)
                op_lui: begin
                    c.exe.exefwd_sel = exefwd_u_imm;
                    c.wb.regfile_sel = rf_u_imm;
                    wr_rd            = 1'b1;
                end
                op_auipc: begin
                    c.exe.alumux1_sel = amux1_pc;
                    c.exe.alumux2_sel = amux2_u_imm;
                    wr_rd             = 1'b1;
                end
                op_jal: begin
                    c.exe.alumux1_sel = amux1_pc;
                    c.exe.alumux2_sel = amux2_j_imm;
                    c.wb.regfile_sel  = rf_pc_plus4;
                    wr_rd             = 1'b1;
                end
                op_jalr: begin
                    c.wb.regfile_sel = rf_pc_plus4;
                    use_o.rs1_used   = 1'b1;
                    wr_rd            = 1'b1;
                end
                op_br: begin
                    c.exe.alumux1_sel = amux1_pc;
                    c.exe.alumux2_sel = amux2_b_imm;
                    c.mem.memfwd_sel  = memfwd_exe;
                    // funct3 010 and 011 name no branch
                    if (ins.funct3 != 3'b010 && ins.funct3 != 3'b011) begin
                        c.exe.cmp_op = cmp_op_e'(ins.funct3);
                    end
                    use_o = 2'b11;
                end
                op_load: begin
                    c.mem.read     = 1'b1;
                    c.mem.funct3   = ins.funct3;
                    c.mem.mar_sel  = mar_alu_out;
                    use_o.rs1_used = 1'b1;
                    wr_rd          = 1'b1;
                    case (ins.funct3)
                        3'b000:  c.wb.regfile_sel = rf_lb;
                        3'b001:  c.wb.regfile_sel = rf_lh;
                        3'b100:  c.wb.regfile_sel = rf_lbu;
                        3'b101:  c.wb.regfile_sel = rf_lhu;
                        default: c.wb.regfile_sel = rf_lw;
                    endcase
                end
                op_store: begin
                    c.exe.alumux2_sel = amux2_s_imm;
                    c.mem.write       = 1'b1;
                    c.mem.funct3      = ins.funct3;
                    c.mem.mar_sel     = mar_alu_out;
                    use_o             = 2'b11;
                end
                op_imm, op_reg: begin
                    c.exe.alumux2_sel = is_r ? amux2_rs2 : amux2_i_imm;
                    c.exe.cmpmux_sel  = is_r ? cmp_rs2 : cmp_i_imm;
                    use_o.rs1_used    = 1'b1;
                    use_o.rs2_used    = is_r;
                    wr_rd             = 1'b1;
                    case (ins.funct3)
                        3'b000:  c.exe.alu_op = (is_r && ins.funct7_5) ? alu_sub : alu_add;
                        3'b001:  c.exe.alu_op = alu_sll;
                        3'b010, 3'b011: begin
                            c.exe.cmp_op     = ins.funct3[0] ? cmp_bltu : cmp_blt;
                            c.exe.exefwd_sel = exefwd_br_en_zext;
                            c.wb.regfile_sel = rf_br_en;
                        end
                        3'b100:  c.exe.alu_op = alu_xor;
                        3'b101:  c.exe.alu_op = ins.funct7_5 ? alu_sra : alu_srl;
                        3'b110:  c.exe.alu_op = alu_or;
                        default: c.exe.alu_op = alu_and;
                    endcase
                end
                default: ;
            endcase
        end
        // loads return their result from memory, other writers from execute
        if (wr_rd) begin
            c.wb.ld_reg = 1'b1;
            c.wb.rd     = ins.rd;
            if (ins.opcode != op_load) begin
                c.mem.memfwd_sel = memfwd_exe;
            end
        end
    endtask

    function automatic fwd_sel_e nearest_match(
        input logic [`RV_REG_ADDR_W-1:0]  rs,
        input logic                       used
    );
        fwd_sel_e sel;
        sel = fwd_rf_data;
        if (used && rs != '0) begin
            if (m_valid[0] && m_tag[0] == rs) begin
                sel = fwd_exe;
            end else if (m_valid[1] && m_tag[1] == rs) begin
                sel = fwd_mem;
            end else if (m_valid[2] && m_tag[2] == rs) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    task automatic check_value(
        input string        name,
        input logic [63:0]  got,
        input logic [63:0]  exp
    );
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // model update from the inputs seen at this edge, then new stimulus
    always @(posedge clk) begin : stim
        logic [31:0]                r0;
        logic [31:0]                r1;
        logic [31:0]                r2;
        logic [31:0]                r3;
        logic [`PIPE_STAGES-1:0]    pend;
        logic                       shift;
        logic [`RV_REG_ADDR_W-1:0]  in_tag;
        decoded_instr_t             ins;
        stage_status_t              st;
        int                         idx;
        int                         idx_exec;

        cycles = cycles + 1;
        pend   = i_status.valid & ~i_status.ready;
        shift  = i_icache_resp && !(|pend[`PIPE_STAGES-1:1]);
        in_tag = (i_status.ready[0] && i_instr.opcode != op_br && i_instr.opcode != op_store)
               ? i_instr.rd : '0;
        if (rst) begin
            m_tag   = '{default: '0};
            m_valid = '0;
            m_br_q  = 1'b0;
        end else begin
            if (shift) begin
                m_tag[2]   = m_tag[1];
                m_valid[2] = m_valid[1];
            end
            // a taken branch empties the two young slots
            if (m_br_q) begin
                m_tag[1]   = '0;
                m_valid[1] = 1'b0;
                m_tag[0]   = '0;
                m_valid[0] = 1'b0;
            end else if (shift) begin
                m_tag[1]   = m_tag[0];
                m_valid[1] = m_valid[0];
                m_tag[0]   = in_tag;
                m_valid[0] = i_status.ready[0];
            end
            m_br_q = i_br_en && (i_opcode_exec == op_br);
        end

        r0       = xorshift(rng);
        r1       = xorshift(r0);
        r2       = xorshift(r1);
        r3       = xorshift(r2);
        rng      = r3;
        idx      = r0[12:5] % 9;
        idx_exec = r3[13:6] % 9;

        // one in 32 opcodes is a raw, mostly illegal value
        ins.opcode   = (r0[4:0] == 5'd0) ? rv_opcode_e'(r0[19:13]) : OPS[idx];
        // registers 0 to 7 only, so tags collide often
        ins.rd       = {2'b00, r1[2:0]};
        ins.rs1      = {2'b00, r1[5:3]};
        ins.rs2      = {2'b00, r1[8:6]};
        ins.funct3   = r1[11:9];
        ins.funct7_5 = r1[12];
        st.valid     = r2[4:0];
        for (int i = 0; i < `PIPE_STAGES; i++) begin
            st.ready[i] = r2[5 + 2 * i] | r2[6 + 2 * i];
        end

        i_instr       <= ins;
        i_status      <= st;
        i_icache_resp <= |r3[1:0];
        i_br_en       <= r3[2];
        case (r3[5:3])
            3'd0, 3'd1, 3'd2: i_opcode_exec <= op_br;
            3'd3:             i_opcode_exec <= op_jal;
            3'd4:             i_opcode_exec <= op_jalr;
            default:          i_opcode_exec <= OPS[idx_exec];
        endcase
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : chk
        ctrl_word_t               exp_ctrl;
        reg_use_t                 use_e;
        logic [`PIPE_STAGES-1:0]  pend;
        logic [`PIPE_STAGES-2:0]  stall;
        pipe_ld_t                 exp_ld;
        pipe_flush_t              exp_flush;
        pcmux_e                   exp_pc;
        logic                     br_now;

        decode_expect(i_instr, i_status.ready[0], exp_ctrl, use_e);
        exp_ctrl.exe.rs1_sel = nearest_match(i_instr.rs1, use_e.rs1_used);
        exp_ctrl.exe.rs2_sel = nearest_match(i_instr.rs2, use_e.rs2_used);

        pend = i_status.valid & ~i_status.ready;
        for (int k = 0; k < `PIPE_STAGES - 1; k++) begin
            stall[k] = |(pend >> (k + 1));
        end
        exp_ld.if_de      = !rst && i_icache_resp && !stall[0];
        exp_ld.de_exe     = !rst && i_icache_resp && !stall[1] && i_status.valid[0];
        exp_ld.exe_mem    = !rst && i_icache_resp && !stall[2] && i_status.valid[1];
        exp_ld.mem_wb     = !rst && i_icache_resp && !stall[3] && i_status.valid[2];
        exp_flush.if_de   = rst || m_br_q;
        exp_flush.de_exe  = rst || m_br_q;
        exp_flush.exe_mem = rst;
        exp_flush.mem_wb  = rst;

        br_now = i_br_en && (i_opcode_exec == op_br);
        if (br_now || i_opcode_exec == op_jal) begin
            exp_pc = pc_alu_out;
        end else if (i_opcode_exec == op_jalr) begin
            exp_pc = pc_alu_mod2;
        end else begin
            exp_pc = pc_plus4;
        end

        check_value("o_ctrl_word.exe", 64'(o_ctrl_word.exe), 64'(exp_ctrl.exe));
        check_value("o_ctrl_word.mem", 64'(o_ctrl_word.mem), 64'(exp_ctrl.mem));
        check_value("o_ctrl_word.wb", 64'(o_ctrl_word.wb), 64'(exp_ctrl.wb));
        check_value("o_ld", 64'(o_ld), 64'(exp_ld));
        check_value("o_flush", 64'(o_flush), 64'(exp_flush));
        check_value("o_imem_read", 64'(o_imem_read),
                    64'(!rst && !i_icache_resp && !stall[0]));
        check_value("o_load_pc", 64'(o_load_pc),
                    64'(!rst && i_icache_resp && (m_br_q || !stall[0])));
        check_value("o_pcmux_sel", 64'(o_pcmux_sel), 64'(exp_pc));
    end

    initial begin : main
        rst           = 1'b1;
        i_instr       = '0;
        i_status      = '0;
        i_icache_resp = 1'b0;
        i_br_en       = 1'b0;
        i_opcode_exec = op_imm;
        rng           = 32'he62ec04c;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        end_run();
    end

    initial begin : watchdog
        while (cycles < TIMEOUT) begin
            @(posedge clk);
        end
        $display("Timeout: run did not end within %0d cycles", TIMEOUT);
        errors++;
        end_run();
    end

endmodule

//--- list.f
+incdir+design
design/pipe_ctrl_pkg.sv
design/instr_decoder.sv
design/hazard_slot.sv
design/forward_select.sv
design/stall_ctrl.sv
design/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert
SIM_FLAGS  := --binary -j 0
TOP        := tb_pipe_ctrl
RTL_TOP    := pipe_ctrl_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
